// File: include/apb_xbar_defs.svh
`ifndef APB_XBAR_DEFS_SVH
`define APB_XBAR_DEFS_SVH

// Bus widths
`define APB_AW 16
`define APB_DW 32
`define APB_SW (`APB_DW / 8)

`define APB_NUM_REQ 2
`define APB_NUM_CPL 4

// Completer windows, limits inclusive
`define APB_CPL_BASE_0  16'h0000
`define APB_CPL_BASE_1  16'h1000
`define APB_CPL_BASE_2  16'h2000
`define APB_CPL_BASE_3  16'h3000
`define APB_CPL_LIMIT_0 16'h0FFF
`define APB_CPL_LIMIT_1 16'h1FFF
`define APB_CPL_LIMIT_2 16'h2FFF
`define APB_CPL_LIMIT_3 16'h3FFF

`define APB_WEIGHT_0 2 // Max consecutive grants
`define APB_WEIGHT_1 1

`define APB_WAIT_0 0
`define APB_WAIT_1 1
`define APB_WAIT_2 2
`define APB_WAIT_3 3

`define APB_BANK_WORDS 16

`endif

// File: project.f
+incdir+include
rtl/apb_pkg.sv
rtl/apb_addr_decode.sv
rtl/wrr_arbiter.sv
rtl/apb_xbar.sv
rtl/apb_regbank.sv
rtl/apb_subsystem_top.sv
tests/tb_apb_subsystem.sv

// File: rtl/apb_addr_decode.sv
`default_nettype none

`include "apb_xbar_defs.svh"

module apb_addr_decode (
    input  wire                    psel,
    input  wire apb_pkg::addr_t    paddr,
    output apb_pkg::cpl_vec_t      cpl_sel,
    output logic                   miss
);
    localparam int C = `APB_NUM_CPL;

    localparam apb_pkg::addr_t BASE [C] = '{
        `APB_CPL_BASE_0, `APB_CPL_BASE_1, `APB_CPL_BASE_2, `APB_CPL_BASE_3
    };
    localparam apb_pkg::addr_t LIMIT [C] = '{
        `APB_CPL_LIMIT_0, `APB_CPL_LIMIT_1, `APB_CPL_LIMIT_2, `APB_CPL_LIMIT_3
    };

    always_comb begin
        cpl_sel = '0;
        for (int j = 0; j < C; j++) begin
            // Lowest window wins on overlap
            if (psel && (cpl_sel == '0) &&
                (paddr >= BASE[j]) && (paddr <= LIMIT[j])) begin
                cpl_sel[j] = 1'b1;
            end
        end
        miss = psel && (cpl_sel == '0); // Outside every window
    end

endmodule : apb_addr_decode

`default_nettype wire

// File: rtl/apb_pkg.sv
`default_nettype none

`include "apb_xbar_defs.svh"

package apb_pkg;

    typedef logic [`APB_AW-1:0] addr_t;
    typedef logic [`APB_DW-1:0] data_t;
    typedef logic [`APB_SW-1:0] strb_t; // One bit per byte lane

    // One-hot selects
    typedef logic [`APB_NUM_REQ-1:0] req_vec_t;
    typedef logic [`APB_NUM_CPL-1:0] cpl_vec_t;

    typedef logic [0:0] req_id_t; // Two requesters only

endpackage : apb_pkg

`default_nettype wire

// File: rtl/apb_regbank.sv
`default_nettype none

`include "apb_xbar_defs.svh"

module apb_regbank #(
    parameter int WAIT_STATES = 0
) (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 psel,
    input  wire                 penable,
    input  wire                 pwrite,
    input  wire apb_pkg::addr_t paddr,
    input  wire apb_pkg::data_t pwdata,
    input  wire apb_pkg::strb_t pstrb,
    output logic                pready,
    output apb_pkg::data_t      prdata,
    output logic                pslverr
);
    localparam int IW = $clog2(`APB_BANK_WORDS);

    apb_pkg::data_t mem [`APB_BANK_WORDS];
    logic [3:0]     wait_cnt;
    logic [9:0]     word_off;
    logic [IW-1:0]  idx;
    logic           access;
    logic           in_range;

    assign access   = psel && penable;
    assign word_off = paddr[11:2];
    assign idx      = word_off[IW-1:0];
    assign in_range = word_off < 10'(`APB_BANK_WORDS);

    assign pready  = access && (wait_cnt == 4'(WAIT_STATES));
    assign pslverr = pready && !in_range; // Past the bank depth
    assign prdata  = in_range ? mem[idx] : '0;

    // Counts ACCESS cycles until pready
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (access && !pready) begin
            wait_cnt <= wait_cnt + 4'd1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem <= '{default: '0};
        end else if (pready && pwrite && in_range) begin
            for (int b = 0; b < `APB_SW; b++) begin
                if (pstrb[b]) begin
                    mem[idx][b*8 +: 8] <= pwdata[b*8 +: 8];
                end
            end
        end
    end

endmodule : apb_regbank

`default_nettype wire

// File: rtl/apb_subsystem_top.sv
`default_nettype none

`include "apb_xbar_defs.svh"

module apb_subsystem_top (
    input  wire                                     clk,
    input  wire                                     arst_n,
    input  wire apb_pkg::req_vec_t                  req_psel,
    input  wire apb_pkg::req_vec_t                  req_penable,
    input  wire apb_pkg::req_vec_t                  req_pwrite,
    input  wire apb_pkg::addr_t [`APB_NUM_REQ-1:0]  req_paddr,
    input  wire apb_pkg::data_t [`APB_NUM_REQ-1:0]  req_pwdata,
    input  wire apb_pkg::strb_t [`APB_NUM_REQ-1:0]  req_pstrb,
    output apb_pkg::req_vec_t                       req_pready,
    output apb_pkg::data_t [`APB_NUM_REQ-1:0]       req_prdata,
    output apb_pkg::req_vec_t                       req_pslverr
);
    localparam int C = `APB_NUM_CPL;
    localparam int WAITS [C] = '{`APB_WAIT_0, `APB_WAIT_1, `APB_WAIT_2, `APB_WAIT_3};

    apb_pkg::cpl_vec_t         cpl_psel;
    apb_pkg::cpl_vec_t         cpl_penable;
    apb_pkg::cpl_vec_t         cpl_pwrite;
    apb_pkg::addr_t [C-1:0]    cpl_paddr;
    apb_pkg::data_t [C-1:0]    cpl_pwdata;
    apb_pkg::strb_t [C-1:0]    cpl_pstrb;
    apb_pkg::cpl_vec_t         cpl_pready;
    apb_pkg::data_t [C-1:0]    cpl_prdata;
    apb_pkg::cpl_vec_t         cpl_pslverr;

    apb_xbar apb_xbar_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_psel    (req_psel),
        .req_penable (req_penable),
        .req_pwrite  (req_pwrite),
        .req_paddr   (req_paddr),
        .req_pwdata  (req_pwdata),
        .req_pstrb   (req_pstrb),
        .req_pready  (req_pready),
        .req_prdata  (req_prdata),
        .req_pslverr (req_pslverr),
        .cpl_psel    (cpl_psel),
        .cpl_penable (cpl_penable),
        .cpl_pwrite  (cpl_pwrite),
        .cpl_paddr   (cpl_paddr),
        .cpl_pwdata  (cpl_pwdata),
        .cpl_pstrb   (cpl_pstrb),
        .cpl_pready  (cpl_pready),
        .cpl_prdata  (cpl_prdata),
        .cpl_pslverr (cpl_pslverr)
    );

    // One bank per window, wait states rising with index
    for (genvar j = 0; j < C; j++) begin : gen_bank
        apb_regbank #(
            .WAIT_STATES (WAITS[j])
        ) apb_regbank_i (
            .clk     (clk),
            .arst_n  (arst_n),
            .psel    (cpl_psel[j]),
            .penable (cpl_penable[j]),
            .pwrite  (cpl_pwrite[j]),
            .paddr   (cpl_paddr[j]),
            .pwdata  (cpl_pwdata[j]),
            .pstrb   (cpl_pstrb[j]),
            .pready  (cpl_pready[j]),
            .prdata  (cpl_prdata[j]),
            .pslverr (cpl_pslverr[j])
        );
    end

endmodule : apb_subsystem_top

`default_nettype wire

// File: rtl/apb_xbar.sv
`default_nettype none

`include "apb_xbar_defs.svh"

module apb_xbar (
    input  wire                                     clk,
    input  wire                                     arst_n,
    // Requester side
    input  wire apb_pkg::req_vec_t                  req_psel,
    input  wire apb_pkg::req_vec_t                  req_penable,
    input  wire apb_pkg::req_vec_t                  req_pwrite,
    input  wire apb_pkg::addr_t [`APB_NUM_REQ-1:0]  req_paddr,
    input  wire apb_pkg::data_t [`APB_NUM_REQ-1:0]  req_pwdata,
    input  wire apb_pkg::strb_t [`APB_NUM_REQ-1:0]  req_pstrb,
    output apb_pkg::req_vec_t                       req_pready,
    output apb_pkg::data_t [`APB_NUM_REQ-1:0]       req_prdata,
    output apb_pkg::req_vec_t                       req_pslverr,
    // Completer side
    output apb_pkg::cpl_vec_t                       cpl_psel,
    output apb_pkg::cpl_vec_t                       cpl_penable,
    output apb_pkg::cpl_vec_t                       cpl_pwrite,
    output apb_pkg::addr_t [`APB_NUM_CPL-1:0]       cpl_paddr,
    output apb_pkg::data_t [`APB_NUM_CPL-1:0]       cpl_pwdata,
    output apb_pkg::strb_t [`APB_NUM_CPL-1:0]       cpl_pstrb,
    input  wire apb_pkg::cpl_vec_t                  cpl_pready,
    input  wire apb_pkg::data_t [`APB_NUM_CPL-1:0]  cpl_prdata,
    input  wire apb_pkg::cpl_vec_t                  cpl_pslverr
);
    localparam int N = `APB_NUM_REQ;
    localparam int C = `APB_NUM_CPL;

    apb_pkg::cpl_vec_t [N-1:0] dec_sel;
    apb_pkg::req_vec_t         dec_miss;
    apb_pkg::req_vec_t [C-1:0] arb_req;
    apb_pkg::req_vec_t [C-1:0] arb_gnt;
    apb_pkg::req_id_t  [C-1:0] arb_gnt_id;
    apb_pkg::cpl_vec_t         arb_gnt_valid;
    apb_pkg::cpl_vec_t         phase;  // Completer in ACCESS
    apb_pkg::cpl_vec_t         done;

    for (genvar i = 0; i < N; i++) begin : gen_dec
        apb_addr_decode apb_addr_decode_i (
            .psel    (req_psel[i]),
            .paddr   (req_paddr[i]),
            .cpl_sel (dec_sel[i]),
            .miss    (dec_miss[i])
        );
    end

    always_comb begin
        for (int j = 0; j < C; j++) begin
            for (int i = 0; i < N; i++) begin
                arb_req[j][i] = dec_sel[i][j]; // Transpose selects
            end
        end
    end

    assign done = phase & cpl_pready;

    for (genvar j = 0; j < C; j++) begin : gen_arb
        wrr_arbiter wrr_arbiter_i (
            .clk       (clk),
            .arst_n    (arst_n),
            .req       (arb_req[j]),
            .done      (done[j]),
            .gnt       (arb_gnt[j]),
            .gnt_valid (arb_gnt_valid[j]),
            .gnt_id    (arb_gnt_id[j])
        );
    end

    // SETUP in the grant cycle, ACCESS from the next one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= '0;
        end else begin
            for (int j = 0; j < C; j++) begin
                if (phase[j]) begin
                    if (cpl_pready[j]) begin
                        phase[j] <= 1'b0;
                    end
                end else if (cpl_psel[j]) begin
                    phase[j] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int j = 0; j < C; j++) begin
            cpl_psel[j]    = arb_gnt_valid[j];
            cpl_penable[j] = phase[j];
            cpl_pwrite[j]  = arb_gnt_valid[j] && req_pwrite[arb_gnt_id[j]];
            cpl_paddr[j]   = arb_gnt_valid[j] ? req_paddr[arb_gnt_id[j]] : '0;
            cpl_pwdata[j]  = arb_gnt_valid[j] ? req_pwdata[arb_gnt_id[j]] : '0;
            cpl_pstrb[j]   = arb_gnt_valid[j] ? req_pstrb[arb_gnt_id[j]] : '0;
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            // Local error answer for a miss
            req_pready[i]  = dec_miss[i] && req_penable[i];
            req_pslverr[i] = dec_miss[i] && req_penable[i];
            req_prdata[i]  = '0;
            for (int j = 0; j < C; j++) begin
                if (arb_gnt[j][i]) begin
                    req_pready[i]  = done[j];
                    req_pslverr[i] = done[j] && cpl_pslverr[j];
                    req_prdata[i]  = cpl_prdata[j];
                end
            end
        end
    end

endmodule : apb_xbar

`default_nettype wire

// File: rtl/wrr_arbiter.sv
`default_nettype none

`include "apb_xbar_defs.svh"

module wrr_arbiter (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire apb_pkg::req_vec_t req,
    input  wire                    done,
    output apb_pkg::req_vec_t      gnt,
    output logic                   gnt_valid,
    output apb_pkg::req_id_t       gnt_id
);
    localparam int N = `APB_NUM_REQ;
    localparam int WEIGHT [N] = '{`APB_WEIGHT_0, `APB_WEIGHT_1};

    logic             locked;     // Grant held until done
    apb_pkg::req_id_t lock_id;
    apb_pkg::req_id_t ptr;        // Priority pointer
    logic [3:0]       use_cnt;    // Consecutive grants at ptr
    logic             pick_valid;
    apb_pkg::req_id_t pick_id;
    apb_pkg::req_id_t next_id;
    logic [3:0]       cnt_next;

    // Round robin search from the pointer
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick_id    = ptr;
        for (int k = 0; k < N; k++) begin
            idx = (int'(ptr) + k) % N;
            if (!pick_valid && req[idx]) begin
                pick_valid = 1'b1;
                pick_id    = apb_pkg::req_id_t'(idx);
            end
        end
    end

    assign gnt_valid = locked || pick_valid;
    assign gnt_id    = locked ? lock_id : pick_id;

    always_comb begin
        gnt = '0;
        if (gnt_valid) begin
            gnt[gnt_id] = 1'b1;
        end
    end

    // Run restarts when the winner was not the pointer
    assign cnt_next = (lock_id == ptr) ? use_cnt + 4'd1 : 4'd1;
    assign next_id  = apb_pkg::req_id_t'((int'(lock_id) + 1) % N);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            locked  <= 1'b0;
            lock_id <= '0;
            ptr     <= '0;
            use_cnt <= '0;
        end else if (locked) begin
            if (done) begin
                locked <= 1'b0;
                if (int'(cnt_next) < WEIGHT[lock_id]) begin
                    ptr     <= lock_id; // Keeps priority
                    use_cnt <= cnt_next;
                end else begin
                    ptr     <= next_id; // Weight used up
                    use_cnt <= '0;
                end
            end
        end else if (pick_valid) begin
            locked  <= 1'b1;
            lock_id <= pick_id;
        end
    end

endmodule : wrr_arbiter

`default_nettype wire

// File: tests/tb_apb_subsystem.sv
`default_nettype none

`include "apb_xbar_defs.svh"

module tb_apb_subsystem;
    localparam int N_RANDOM   = 60; // Per requester, any completer
    localparam int N_PARALLEL = 40; // Per requester, own pair of completers
    localparam int N_CONTEND  = 8;  // Requester 1 on completer 2, requester 0 does twice
    localparam int TOTAL      = 2 * N_RANDOM + 2 * N_PARALLEL + 3 * N_CONTEND;
    localparam int WAITS [`APB_NUM_CPL] = '{`APB_WAIT_0, `APB_WAIT_1, `APB_WAIT_2, `APB_WAIT_3};

    logic                               clk;
    logic                               arst_n;
    apb_pkg::req_vec_t                  req_psel;
    apb_pkg::req_vec_t                  req_penable;
    apb_pkg::req_vec_t                  req_pwrite;
    apb_pkg::addr_t [`APB_NUM_REQ-1:0]  req_paddr;
    apb_pkg::data_t [`APB_NUM_REQ-1:0]  req_pwdata;
    apb_pkg::strb_t [`APB_NUM_REQ-1:0]  req_pstrb;
    apb_pkg::req_vec_t                  req_pready;
    apb_pkg::data_t [`APB_NUM_REQ-1:0]  req_prdata;
    apb_pkg::req_vec_t                  req_pslverr;

    logic [31:0] lcg_state = 32'h0fa72bac;
    logic [31:0] model [`APB_NUM_CPL][`APB_BANK_WORDS] = '{default: '0}; // Expected bank contents
    int          errors = 0;
    bit          record_order = 1'b0;
    int          order_q [$];  // Requester ids in completion order

    apb_subsystem_top apb_subsystem_top_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_psel    (req_psel),
        .req_penable (req_penable),
        .req_pwrite  (req_pwrite),
        .req_paddr   (req_paddr),
        .req_pwdata  (req_pwdata),
        .req_pstrb   (req_pstrb),
        .req_pready  (req_pready),
        .req_prdata  (req_prdata),
        .req_pslverr (req_pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int unsigned rand_below(input int unsigned n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return (lcg_state >> 8) % n; // Low LCG bits are weak
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic idle(input int r, input int n);
        repeat (n) begin
            @(posedge clk);
            req_psel[r]    <= 1'b0;
            req_penable[r] <= 1'b0;
        end
    endtask

    // One APB transfer, checked at the cycle where pready is seen
    task automatic do_transfer(input int r, input logic wr, input apb_pkg::addr_t addr,
                               input apb_pkg::data_t wdata, input apb_pkg::strb_t strb,
                               input bit strict);
        int   cycles;
        int   c;
        int   off;
        int   b;
        int   exp_cycles;
        logic miss;
        logic bad_off;
        cycles     = 0;
        miss       = addr > 16'h3FFF;
        c          = addr[13:12];
        off        = addr[11:2];
        bad_off    = !miss && (off >= `APB_BANK_WORDS);
        exp_cycles = miss ? 1 : WAITS[c] + 1;
        @(posedge clk);
        req_psel[r]    <= 1'b1; // SETUP
        req_penable[r] <= 1'b0;
        req_pwrite[r]  <= wr;
        req_paddr[r]   <= addr;
        req_pwdata[r]  <= wdata;
        req_pstrb[r]   <= strb;
        @(posedge clk);
        req_penable[r] <= 1'b1;
        do begin
            @(negedge clk);
            cycles++;
        end while (!req_pready[r]);
        check_value($sformatf("req_pslverr[%0d]", r), 32'(miss || bad_off), 32'(req_pslverr[r]));
        if (!wr && !miss) begin
            check_value($sformatf("req_prdata[%0d]", r), bad_off ? 32'h0 : model[c][off],
                        req_prdata[r]);
        end
        if (wr && !miss && !bad_off) begin
            for (b = 0; b < `APB_SW; b++) begin
                if (strb[b]) begin
                    model[c][off][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
        if (strict || miss) begin
            check_value($sformatf("access cycles of requester %0d", r), exp_cycles, cycles);
        end else begin
            // Contention only adds cycles
            check_value($sformatf("minimum access cycles of requester %0d", r), 32'd1,
                        32'(cycles >= exp_cycles));
        end
        if (record_order) begin
            order_q.push_back(r);
        end
    endtask

    // Mode 0 any completer, mode 1 disjoint pairs, mode 2 completer 2 back to back
    task automatic run_traffic(input int r, input int count, input int mode);
        int             n;
        int             c;
        int             off;
        int             gap;
        logic           wr;
        apb_pkg::addr_t addr;
        apb_pkg::data_t wdata;
        apb_pkg::strb_t strb;
        for (n = 0; n < count; n++) begin
            c    = (mode == 0) ? rand_below(4) : (mode == 1) ? 2 * r + rand_below(2) : 2;
            off  = (rand_below(8) == 0) ? 16 + rand_below(1008) : rand_below(16);
            addr = apb_pkg::addr_t'((c << 12) | (off << 2));
            if (mode != 2 && rand_below(8) == 0) begin
                addr = 16'h4000 | apb_pkg::addr_t'(rand_below(65536)); // Above every window
            end
            wr    = rand_below(2);
            wdata = {16'(rand_below(65536)), 16'(rand_below(65536))};
            strb  = apb_pkg::strb_t'(rand_below(16));
            gap   = (mode == 2) ? 0 : rand_below(4);
            do_transfer(r, wr, addr, wdata, strb, mode == 1);
            idle(r, gap);
        end
        idle(r, 1);
    endtask

    initial begin
        int first;
        int k;
        arst_n      = 1'b0;
        req_psel    = '0;
        req_penable = '0;
        req_pwrite  = '0;
        req_paddr   = '0;
        req_pwdata  = '0;
        req_pstrb   = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        fork
            run_traffic(0, N_RANDOM, 0);
            run_traffic(1, N_RANDOM, 0);
        join
        fork
            run_traffic(0, N_PARALLEL, 1);
            run_traffic(1, N_PARALLEL, 1);
        join
        record_order = 1'b1;
        fork
            run_traffic(0, 2 * N_CONTEND, 2);
            run_traffic(1, N_CONTEND, 2);
        join
        // Arbiter state at the start is unknown, so align on requester 1
        first = -1;
        for (k = 0; k < order_q.size(); k++) begin
            if (first < 0 && order_q[k] == 1) begin
                first = k;
            end
        end
        if (first < 0 || order_q.size() < first + 12) begin
            errors++;
            $display("Too few completions on completer 2 to check the arbitration order");
        end else begin
            for (k = 0; k < 12; k++) begin
                check_value("grant order on completer 2", 32'(k % 3 == 0), order_q[first + k]);
            end
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (TOTAL * 40) @(posedge clk);
        $display("Watchdog expired: transfers stopped completing, errors so far %0d", errors);
        $display("Done: errors found");
        $finish;
    end

endmodule : tb_apb_subsystem

`default_nettype wire
